// File: flist.f
hw/lsu_pkg.sv
hw/lsu_decode.sv
hw/wait_ctrl.sv
hw/store_align.sv
hw/byte_bank.sv
hw/load_align.sv
hw/data_mem_unit.sv
test/tb_data_mem_unit.sv

// File: hw/byte_bank.sv
`timescale 1ns/1ps
`default_nettype none

module byte_bank (
    input  wire logic                            clk,
    input  wire logic                            we,
    input  wire logic                            rd_en,
    input  wire logic [lsu_pkg::WORD_ADDR_W-1:0] addr,
    input  wire logic [7:0]                      wdata,
    output logic      [7:0]                      rdata
);
    import lsu_pkg::*;

    // one byte lane of the data memory
    logic [7:0] mem [0:MEM_WORDS-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: hw/data_mem_unit.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem_unit (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           inst_valid,
    input  wire lsu_pkg::inst_u inst,
    input  wire logic [31:0]    rs1_value,
    input  wire logic [31:0]    rs2_value,
    output logic      [31:0]    load_data,
    output logic                load_valid,
    output logic                stall
);
    import lsu_pkg::*;

    mem_op_t     op;
    bank_wr_t    wr;
    logic        rd_en;
    logic [31:0] rd_word;

    lsu_decode u_decode (
        .inst_valid (inst_valid),
        .inst       (inst),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value),
        .op         (op)
    );

    wait_ctrl u_wait (
        .clk        (clk),
        .reset      (reset),
        .op         (op),
        .stall      (stall),
        .rd_en      (rd_en),
        .load_valid (load_valid)
    );

    store_align u_store (
        .op (op),
        .wr (wr)
    );

    // four byte lanes, lane i holds byte i of each word
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        byte_bank u_bank (
            .clk   (clk),
            .we    (wr.we[i]),
            .rd_en (rd_en),
            .addr  (wr.word_addr),
            .wdata (wr.wdata[8*i +: 8]),
            .rdata (rd_word[8*i +: 8])
        );
    end

    load_align u_load (
        .op         (op),
        .rd_word    (rd_word),
        .load_valid (load_valid),
        .load_data  (load_data)
    );

endmodule

`default_nettype wire

// File: hw/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  wire lsu_pkg::mem_op_t op,
    input  wire logic [31:0]      rd_word,
    input  wire logic             load_valid,
    output logic      [31:0]      load_data
);
    import lsu_pkg::*;

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic [31:0] ext;

    always_comb begin
        case (op.byte_off)
            2'd0: sel_byte = rd_word[7:0];
            2'd1: sel_byte = rd_word[15:8];
            2'd2: sel_byte = rd_word[23:16];
            default: sel_byte = rd_word[31:24];
        endcase
        // bit 0 of the offset is ignored for halfwords
        sel_half = op.byte_off[1] ? rd_word[31:16] : rd_word[15:0];
    end

    always_comb begin
        case (op.funct3)
            F3_B: ext = {{24{sel_byte[7]}}, sel_byte};
            F3_H: ext = {{16{sel_half[15]}}, sel_half};
            F3_BU: ext = {24'd0, sel_byte};
            F3_HU: ext = {16'd0, sel_half};
            default: ext = rd_word;
        endcase
    end

    // zero outside the valid cycle
    assign load_data = load_valid ? ext : 32'd0;

endmodule

`default_nettype wire

// File: hw/lsu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_decode (
    input  wire logic           inst_valid,
    input  wire lsu_pkg::inst_u inst,
    input  wire logic [31:0]    rs1_value,
    input  wire logic [31:0]    rs2_value,
    output lsu_pkg::mem_op_t    op
);
    import lsu_pkg::*;

    logic        is_load;
    logic        is_store;
    logic [31:0] imm;
    logic [31:0] addr;

    // legality of opcode and funct3
    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        if (inst_valid) begin
            if (inst.i_view.opcode == OPC_LOAD) begin
                case (inst.i_view.funct3)
                    F3_B, F3_H, F3_W, F3_BU, F3_HU: is_load = 1'b1;
                    default: is_load = 1'b0;
                endcase
            end else if (inst.s_view.opcode == OPC_STORE) begin
                case (inst.s_view.funct3)
                    F3_B, F3_H, F3_W: is_store = 1'b1;
                    default: is_store = 1'b0;
                endcase
            end
        end
    end

    // stores split the immediate around rs2
    always_comb begin
        if (is_store) begin
            imm = {{20{inst.s_view.imm_hi[6]}}, inst.s_view.imm_hi, inst.s_view.imm_lo};
        end else begin
            imm = {{20{inst.i_view.imm[11]}}, inst.i_view.imm};
        end
    end

    assign addr = rs1_value + imm;

    always_comb begin
        op.kind      = is_load ? OP_LOAD : (is_store ? OP_STORE : OP_NONE);
        op.funct3    = inst.i_view.funct3;
        op.byte_off  = addr[1:0];
        // upper address bits wrap inside the memory
        op.word_addr = addr[WORD_ADDR_W+1:2];
        op.wdata     = is_store ? rs2_value : 32'd0;
    end

endmodule

`default_nettype wire

// File: hw/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // memory geometry
    localparam int MEM_WORDS   = 4096;
    localparam int WORD_ADDR_W = $clog2(MEM_WORDS);
    localparam int LANES       = 4;

    // load latency in wait cycles before the banks are read
    localparam int LOAD_WAIT = 4;
    localparam int CNT_W     = $clog2(LOAD_WAIT + 1);

    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // funct3 size codes
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    // one instruction word, two field layouts
    typedef union packed {
        i_type_t i_view;
        s_type_t s_view;
    } inst_u;

    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } op_kind_e;

    typedef struct packed {
        op_kind_e               kind;
        logic [2:0]             funct3;
        logic [1:0]             byte_off;
        logic [WORD_ADDR_W-1:0] word_addr;
        logic [31:0]            wdata;
    } mem_op_t;

    // wdata lanes already shifted into place
    typedef struct packed {
        logic [LANES-1:0]       we;
        logic [WORD_ADDR_W-1:0] word_addr;
        logic [31:0]            wdata;
    } bank_wr_t;

endpackage

`default_nettype wire

// File: hw/store_align.sv
`timescale 1ns/1ps
`default_nettype none

module store_align (
    input  wire lsu_pkg::mem_op_t op,
    output lsu_pkg::bank_wr_t     wr
);
    import lsu_pkg::*;

    always_comb begin
        wr.word_addr = op.word_addr;
        wr.we        = '0;
        wr.wdata     = op.wdata;
        if (op.kind == OP_STORE) begin
            case (op.funct3)
                F3_B: begin
                    // same byte in every lane, enable picks one
                    wr.we    = LANES'(1) << op.byte_off;
                    wr.wdata = {4{op.wdata[7:0]}};
                end
                F3_H: begin
                    // halfword position from offset bit 1
                    wr.we    = op.byte_off[1] ? 4'b1100 : 4'b0011;
                    wr.wdata = {2{op.wdata[15:0]}};
                end
                F3_W: begin
                    wr.we = '1;
                end
                default: begin
                    wr.we = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/wait_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module wait_ctrl (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire lsu_pkg::mem_op_t op,
    output logic                  stall,
    output logic                  rd_en,
    output logic                  load_valid
);
    import lsu_pkg::*;

    logic             is_load;
    logic [CNT_W-1:0] count;

    assign is_load = (op.kind == OP_LOAD);

    // read the banks once the wait is over
    assign rd_en = is_load && (count == CNT_W'(LOAD_WAIT));

    // counter restarts after the read so a held load counts again
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (!is_load || rd_en) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // valid follows the bank read by one edge
    always_ff @(posedge clk) begin
        if (reset) begin
            load_valid <= 1'b0;
        end else begin
            load_valid <= rd_en;
        end
    end

    // Stores and invalid requests never stall.
    assign stall = is_load && !load_valid;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_data_mem_unit -f flist.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1

// File: test/tb_data_mem_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_data_mem_unit;
    import lsu_pkg::*;

    localparam int MAX_CYCLES = 6000;
    localparam int AW = WORD_ADDR_W + 2;

    logic        clk = 1'b0;
    logic        reset;
    logic        inst_valid;
    inst_u       inst;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    logic [31:0] load_data;
    logic        load_valid;
    logic        stall;

    // reference memory with one word per entry
    logic [31:0] model [0:MEM_WORDS-1];
    int          errors = 0;
    int          ops = 0;
    int          cycles = 0;
    int unsigned seed;

    data_mem_unit DUT (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value),
        .load_data  (load_data),
        .load_valid (load_valid),
        .stall      (stall)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run was still going after %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [31:0] i_type_word(input logic [2:0] f3, input logic [11:0] imm);
        return {imm, 5'd1, f3, 5'd2, OPC_LOAD};
    endfunction

    function automatic logic [31:0] s_type_word(input logic [2:0] f3, input logic [11:0] imm,
                                                input logic [6:0] opc);
        return {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], opc};
    endfunction

    // expected load result from the model word
    function automatic logic [31:0] predict_load(input logic [2:0] f3, input logic [AW-1:0] addr);
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        word = model[addr[AW-1:2]];
        b = word[8*addr[1:0] +: 8];
        h = word[16*addr[1] +: 16];
        case (f3)
            F3_B: return {{24{b[7]}}, b};
            F3_H: return {{16{h[15]}}, h};
            F3_BU: return {24'd0, b};
            F3_HU: return {16'd0, h};
            default: return word;
        endcase
    endfunction

    task automatic flag_error(input string msg);
        $display("Fail %0t: %s", $time, msg);
        errors++;
    endtask

    // random immediate with rs1 chosen so the sum lands on addr
    task automatic split_addr(input logic [AW-1:0] addr, output logic [31:0] rs1,
                              output logic [11:0] imm);
        logic [31:0] r;
        r = $urandom;
        imm = r[11:0];
        r = $urandom;
        rs1 = {r[31:AW], addr} - {{20{imm[11]}}, imm};
    endtask

    task automatic present(input logic v, input logic [31:0] word, input logic [31:0] rs1,
                           input logic [31:0] rs2);
        inst_valid = v;
        inst = word;
        rs1_value = rs1;
        rs2_value = rs2;
        ops++;
    endtask

    task automatic do_store(input logic [2:0] f3, input logic [AW-1:0] addr,
                            input logic [31:0] data);
        logic [31:0] rs1;
        logic [11:0] imm;
        split_addr(addr, rs1, imm);
        present(1'b1, s_type_word(f3, imm, OPC_STORE), rs1, data);
        #1;
        if (stall !== 1'b0)
            flag_error($sformatf("store at %h raised stall", addr));
        @(negedge clk);
        inst_valid = 1'b0;
        // byte-enable merge into the model word
        case (f3)
            F3_B: model[addr[AW-1:2]][8*addr[1:0] +: 8] = data[7:0];
            F3_H: model[addr[AW-1:2]][16*addr[1] +: 16] = data[15:0];
            default: model[addr[AW-1:2]] = data;
        endcase
    endtask

    task automatic do_load(input logic [2:0] f3, input logic [AW-1:0] addr);
        logic [31:0] rs1;
        logic [11:0] imm;
        logic [31:0] expected;
        int          edges;
        logic        done;
        split_addr(addr, rs1, imm);
        expected = predict_load(f3, addr);
        present(1'b1, i_type_word(f3, imm), rs1, $urandom);
        #1;
        if (stall !== 1'b1)
            flag_error($sformatf("load at %h did not raise stall", addr));
        edges = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            edges++;
            if (load_valid === 1'b1) begin
                done = 1'b1;
            end else if (edges > LOAD_WAIT + 3) begin
                $display("load at %h never raised load_valid", addr);
                errors++;
                done = 1'b1;
            end else if (stall !== 1'b1) begin
                flag_error($sformatf("stall dropped early, load at %h", addr));
            end
        end
        if (edges != LOAD_WAIT + 1 || stall !== 1'b0)
            flag_error($sformatf("load_valid after %0d edges, stall %b", edges, stall));
        if (load_data !== expected)
            flag_error($sformatf("load f3=%0d at %h got %h expected %h",
                                 f3, addr, load_data, expected));
        inst_valid = 1'b0;
        @(negedge clk);
        if (load_valid !== 1'b0 || load_data !== 32'd0)
            flag_error("load_valid or load_data not cleared after the pulse");
    endtask

    // rs2 carries the inverted word so a stray write would show
    task automatic present_invalid(input logic v, input logic [2:0] f3, input logic [6:0] opc,
                                   input logic [AW-1:0] addr);
        logic [31:0] rs1;
        logic [11:0] imm;
        split_addr(addr, rs1, imm);
        present(v, s_type_word(f3, imm, opc), rs1, ~model[addr[AW-1:2]]);
        repeat (2) begin
            #1;
            if (stall !== 1'b0 || load_valid !== 1'b0)
                flag_error($sformatf("invalid request opc=%h f3=%0d raised stall", opc, f3));
            @(negedge clk);
        end
        inst_valid = 1'b0;
    endtask

    task automatic word_round_trip();
        logic [31:0] r;
        for (int i = 0; i < 40; i++) begin
            r = $urandom;
            do_store(F3_W, r[AW-1:0], $urandom);
            // low bits are ignored for words
            do_load(F3_W, {r[AW-1:2], r[AW+1:AW]});
        end
    endtask

    // each partial store is read back while the other bytes still hold older data
    task automatic partial_stores();
        logic [31:0] r;
        for (int i = 0; i < 15; i++) begin
            r = $urandom;
            do_store(F3_W, {r[AW-1:2], 2'b00}, $urandom);
            for (int off = 0; off < 4; off++) begin
                do_store(F3_B, {r[AW-1:2], 2'(off)}, $urandom);
                do_load(F3_W, {r[AW-1:2], 2'b00});
            end
            do_store(F3_H, {r[AW-1:2], 1'b0, r[0]}, $urandom);
            do_load(F3_W, {r[AW-1:2], 2'b00});
            do_store(F3_H, {r[AW-1:2], 1'b1, r[1]}, $urandom);
            do_load(F3_W, {r[AW-1:2], 2'b00});
        end
    endtask

    task automatic load_extension();
        logic [31:0] r;
        for (int i = 0; i < 8; i++) begin
            r = $urandom;
            do_store(F3_W, {r[AW-1:2], 2'b00}, $urandom | 32'h8080_8080);
            for (int off = 0; off < 4; off++) begin
                do_load(F3_B, {r[AW-1:2], 2'(off)});
                do_load(F3_BU, {r[AW-1:2], 2'(off)});
                if (off % 2 == 0) begin
                    do_load(F3_H, {r[AW-1:2], 2'(off)});
                    do_load(F3_HU, {r[AW-1:2], 2'(off)});
                end
            end
        end
    endtask

    task automatic invalid_requests();
        logic [31:0] r;
        r = $urandom;
        do_store(F3_W, {r[AW-1:2], 2'b00}, $urandom);
        present_invalid(1'b1, 3'b011, OPC_LOAD, {r[AW-1:2], 2'b00});
        present_invalid(1'b1, 3'b100, OPC_STORE, {r[AW-1:2], 2'b00});
        present_invalid(1'b1, F3_W, 7'b0110011, {r[AW-1:2], 2'b00});
        present_invalid(1'b0, F3_W, OPC_STORE, {r[AW-1:2], 2'b00});
        present_invalid(1'b0, F3_W, OPC_LOAD, {r[AW-1:2], 2'b00});
        do_load(F3_W, {r[AW-1:2], 2'b00});
    endtask

    initial begin
        seed = $urandom(82553);
        reset = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        rs1_value = 32'd0;
        rs2_value = 32'd0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if (stall !== 1'b0 || load_valid !== 1'b0 || load_data !== 32'd0)
            flag_error("outputs not idle after reset");
        word_round_trip();
        partial_stores();
        load_extension();
        invalid_requests();
        $display("%0d operations, %0d errors", ops, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
